/* rtl/rotor_pkg.sv */
`default_nettype none

package rotor_pkg;

	// word and memory geometry.
	localparam int WORD_W = 48;
	localparam int ADDR_W = 4;
	localparam int DEPTH = 16;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [2:0] proc_t;

	// the datapath count at which the transformed word may be written back.
	localparam proc_t PROC_READY = 3'd4;

	// every fixed wait phase of the controller lasts this many cycles.
	localparam int WAIT_LEN = 8;

	// one init write per memory word.
	localparam int INIT_LEN = DEPTH;

	// transform applied on each step: xor with the key, then rotate left.
	localparam word_t TRANSFORM_KEY = 48'h5a3c_96e1_0f2d;
	localparam int ROT_AMOUNT = 5;

endpackage

`default_nettype wire

/* rtl/state_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module state_memory #(
	parameter type word_type = rotor_pkg::word_t
) (
	input wire logic clock,
	input wire logic write_enable,
	input wire rotor_pkg::addr_t mem_addr,
	input wire word_type data_in,
	output word_type mem_rdata,
	input wire rotor_pkg::addr_t read_addr,
	output word_type read_data
);

	word_type mem [rotor_pkg::DEPTH];

	// a single write port shared by init and write-back.
	always_ff @(posedge clock) begin
		if (write_enable) begin
			mem[mem_addr] <= data_in;
		end
	end

	// the datapath reads at the controller address.
	assign mem_rdata = mem[mem_addr];

	// the outside sees any word through its own port.
	assign read_data = mem[read_addr];

endmodule

`default_nettype wire

/* rtl/memory_control.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_control (
	input wire logic clock,
	input wire logic resetn,
	input wire logic init_memory,
	input wire logic load_memory,
	input wire rotor_pkg::word_t seed,
	input wire rotor_pkg::addr_t op_addr,
	input wire rotor_pkg::word_t datapath_out,
	input wire rotor_pkg::proc_t process,
	output logic write_enable,
	output logic load_registers,
	output logic done,
	output logic finished_init,
	output rotor_pkg::addr_t mem_addr,
	output rotor_pkg::word_t data_in
);

	localparam int PHASE_MAX = (rotor_pkg::INIT_LEN > rotor_pkg::WAIT_LEN) ?
		rotor_pkg::INIT_LEN : rotor_pkg::WAIT_LEN;
	localparam int PHASE_W = $clog2(PHASE_MAX);
	localparam logic [PHASE_W-1:0] INIT_LAST = PHASE_W'(rotor_pkg::INIT_LEN - 1);
	localparam logic [PHASE_W-1:0] WAIT_LAST = PHASE_W'(rotor_pkg::WAIT_LEN - 1);

	typedef enum logic [2:0] {
		ST_INIT,
		ST_INIT_BUF,
		ST_IDLE,
		ST_LOAD,
		ST_WAIT,
		ST_HOLD,
		ST_WRITE
	} state_t;

	state_t state;
	state_t state_next;
	logic [PHASE_W-1:0] phase;
	logic timed;
	logic init_done;
	logic wait_done;

	// states that end after a fixed number of cycles.
	assign timed = (state == ST_INIT) || (state == ST_INIT_BUF) || (state == ST_LOAD) ||
		(state == ST_WAIT) || (state == ST_WRITE);

	assign init_done = (phase == INIT_LAST);
	assign wait_done = (phase == WAIT_LAST);

	always_comb begin
		state_next = state;
		case (state)
			ST_INIT: begin
				if (init_done) state_next = ST_INIT_BUF;
			end
			// the buffer lets the sequencer drop init_memory before idle is reached.
			ST_INIT_BUF: begin
				if (wait_done) state_next = ST_IDLE;
			end
			ST_IDLE: begin
				if (init_memory) begin
					state_next = ST_INIT;
				end else if (load_memory) begin
					state_next = ST_LOAD;
				end
			end
			ST_LOAD: begin
				if (wait_done) state_next = ST_WAIT;
			end
			ST_WAIT: begin
				if (wait_done) state_next = ST_HOLD;
			end
			ST_HOLD: begin
				if (process == rotor_pkg::PROC_READY) state_next = ST_WRITE;
			end
			ST_WRITE: begin
				if (wait_done) state_next = ST_IDLE;
			end
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (resetn) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// one phase counter serves every timed state and restarts on each change.
	always_ff @(posedge clock) begin
		if (resetn) begin
			phase <= '0;
		end else if (state_next != state) begin
			phase <= '0;
		end else if (timed) begin
			phase <= phase + 1'b1;
		end
	end

	assign write_enable = (state == ST_INIT) || (state == ST_WRITE);
	assign load_registers = (state == ST_WAIT);
	assign done = (state == ST_IDLE);
	assign finished_init = (state == ST_INIT_BUF);

	// during init the phase count is also the write address.
	always_comb begin
		if (state == ST_INIT) begin
			mem_addr = rotor_pkg::addr_t'(phase);
			data_in = seed + rotor_pkg::word_t'(phase);
		end else begin
			mem_addr = op_addr;
			data_in = datapath_out;
		end
	end

	// the datapath must keep its finished count for the whole write-back.
	no_write_before_ready: assert property (
		@(posedge clock) disable iff (resetn)
		(state == ST_WRITE) |-> (process == rotor_pkg::PROC_READY)
	);

	load_only_when_idle: assert property (
		@(posedge clock) disable iff (resetn)
		load_memory |-> done
	);

endmodule

`default_nettype wire

/* rtl/word_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module word_datapath (
	input wire logic clock,
	input wire logic resetn,
	input wire logic load_registers,
	input wire logic done,
	input wire rotor_pkg::word_t mem_rdata,
	output rotor_pkg::proc_t process,
	output rotor_pkg::word_t datapath_out
);

	localparam rotor_pkg::proc_t STEP_XOR = 3'd1;
	localparam rotor_pkg::proc_t STEP_ROT = 3'd2;

	rotor_pkg::word_t work_word;
	logic load_q;
	logic load_fell;

	function automatic rotor_pkg::word_t rotate_left(input rotor_pkg::word_t value);
		return (value << rotor_pkg::ROT_AMOUNT) |
			(value >> (rotor_pkg::WORD_W - rotor_pkg::ROT_AMOUNT));
	endfunction

	always_ff @(posedge clock) begin
		if (resetn) begin
			load_q <= 1'b0;
		end else begin
			load_q <= load_registers;
		end
	end

	// processing starts once the controller stops loading.
	assign load_fell = load_q && !load_registers;

	// the count climbs to the ready value and holds there until idle.
	always_ff @(posedge clock) begin
		if (resetn) begin
			process <= '0;
		end else if (done) begin
			process <= '0;
		end else if (load_fell) begin
			process <= STEP_XOR;
		end else if (process != '0 && process != rotor_pkg::PROC_READY) begin
			process <= process + 1'b1;
		end
	end

	// steps past the rotate only hold the word.
	always_ff @(posedge clock) begin
		if (load_registers) begin
			work_word <= mem_rdata;
		end else if (process == STEP_XOR) begin
			work_word <= work_word ^ rotor_pkg::TRANSFORM_KEY;
		end else if (process == STEP_ROT) begin
			work_word <= rotate_left(work_word);
		end
	end

	assign datapath_out = work_word;

	process_in_range: assert property (
		@(posedge clock) disable iff (resetn)
		process <= rotor_pkg::PROC_READY
	);

endmodule

`default_nettype wire

/* rtl/step_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module step_sequencer (
	input wire logic clock,
	input wire logic resetn,
	input wire logic init_cmd,
	input wire logic step_cmd,
	input wire rotor_pkg::addr_t step_addr,
	input wire logic done,
	input wire logic finished_init,
	output logic init_memory,
	output logic load_memory,
	output rotor_pkg::addr_t op_addr,
	output logic busy
);

	typedef enum logic [2:0] {
		SQ_IDLE,
		SQ_INIT_REQ,
		SQ_INIT_DRAIN,
		SQ_STEP_REQ,
		SQ_STEP_RUN
	} seq_state_t;

	seq_state_t state;
	seq_state_t state_next;
	logic accept_init;
	logic accept_step;

	// init wins when both commands arrive together.
	assign accept_init = !busy && init_cmd;
	assign accept_step = !busy && step_cmd && !init_cmd;

	always_comb begin
		state_next = state;
		case (state)
			SQ_IDLE: begin
				if (accept_init) begin
					state_next = SQ_INIT_REQ;
				end else if (accept_step) begin
					state_next = SQ_STEP_REQ;
				end
			end
			SQ_INIT_REQ: begin
				if (finished_init) state_next = SQ_INIT_DRAIN;
			end
			// the controller is idle again once its init buffer ends.
			SQ_INIT_DRAIN: begin
				if (!finished_init) state_next = SQ_IDLE;
			end
			SQ_STEP_REQ: begin
				if (done) state_next = SQ_STEP_RUN;
			end
			SQ_STEP_RUN: begin
				if (done) state_next = SQ_IDLE;
			end
			default: state_next = SQ_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (resetn) begin
			state <= SQ_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clock) begin
		if (accept_step) begin
			op_addr <= step_addr;
		end
	end

	assign busy = (state != SQ_IDLE);
	assign init_memory = (state == SQ_INIT_REQ);

	// the pulse lasts one cycle since the state moves on with it.
	assign load_memory = (state == SQ_STEP_REQ) && done;

	// the controller must leave idle right after it is handed a step.
	step_request_taken: assert property (
		@(posedge clock) disable iff (resetn)
		load_memory |=> !done
	);

endmodule

`default_nettype wire

/* rtl/rotor_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rotor_top (
	input wire logic clock,
	input wire logic resetn,
	input wire logic init_cmd,
	input wire logic step_cmd,
	input wire rotor_pkg::addr_t step_addr,
	input wire rotor_pkg::word_t seed,
	input wire rotor_pkg::addr_t read_addr,
	output rotor_pkg::word_t read_data,
	output logic busy
);

	logic init_memory;
	logic load_memory;
	logic done;
	logic finished_init;
	logic write_enable;
	logic load_registers;
	rotor_pkg::addr_t op_addr;
	rotor_pkg::addr_t mem_addr;
	rotor_pkg::word_t data_in;
	rotor_pkg::word_t mem_rdata;
	rotor_pkg::word_t datapath_out;
	rotor_pkg::proc_t process;

	step_sequencer i_sequencer (
		.clock(clock),
		.resetn(resetn),
		.init_cmd(init_cmd),
		.step_cmd(step_cmd),
		.step_addr(step_addr),
		.done(done),
		.finished_init(finished_init),
		.init_memory(init_memory),
		.load_memory(load_memory),
		.op_addr(op_addr),
		.busy(busy)
	);

	memory_control i_control (
		.clock(clock),
		.resetn(resetn),
		.init_memory(init_memory),
		.load_memory(load_memory),
		.seed(seed),
		.op_addr(op_addr),
		.datapath_out(datapath_out),
		.process(process),
		.write_enable(write_enable),
		.load_registers(load_registers),
		.done(done),
		.finished_init(finished_init),
		.mem_addr(mem_addr),
		.data_in(data_in)
	);

	word_datapath i_datapath (
		.clock(clock),
		.resetn(resetn),
		.load_registers(load_registers),
		.done(done),
		.mem_rdata(mem_rdata),
		.process(process),
		.datapath_out(datapath_out)
	);

	state_memory #(
		.word_type(rotor_pkg::word_t)
	) i_memory (
		.clock(clock),
		.write_enable(write_enable),
		.mem_addr(mem_addr),
		.data_in(data_in),
		.mem_rdata(mem_rdata),
		.read_addr(read_addr),
		.read_data(read_data)
	);

endmodule

`default_nettype wire

/* bench/tb_rotor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rotor;

	localparam int CLOCK_PERIOD = 10;
	localparam int REPEAT_STEPS = 6;
	localparam int RANDOM_STEPS = 30;
	// two inits, one single step, the repeated and random runs, one step
	// carrying ignored pulses and two closing steps.
	localparam int NUM_COMMANDS = 2 + 1 + REPEAT_STEPS + RANDOM_STEPS + 1 + 2;
	localparam int TIMEOUT_CYCLES = NUM_COMMANDS * 64 + 200;
	localparam logic [31:0] RAND_SEED = 32'hf002172e;

	logic clock;
	logic resetn;
	logic init_cmd;
	logic step_cmd;
	rotor_pkg::addr_t step_addr;
	rotor_pkg::word_t seed;
	rotor_pkg::addr_t read_addr;
	rotor_pkg::word_t read_data;
	logic busy;

	rotor_pkg::word_t shadow [rotor_pkg::DEPTH];
	logic sweep_req;
	int error_count;
	int check_count;
	int cycle_count;

	rotor_top i_dut (
		.clock(clock),
		.resetn(resetn),
		.init_cmd(init_cmd),
		.step_cmd(step_cmd),
		.step_addr(step_addr),
		.seed(seed),
		.read_addr(read_addr),
		.read_data(read_data),
		.busy(busy)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// one step of the model: xor with the key, then rotate left.
	function automatic rotor_pkg::word_t ref_step(input rotor_pkg::word_t value);
		rotor_pkg::word_t mixed;
		mixed = value ^ rotor_pkg::TRANSFORM_KEY;
		return {mixed[rotor_pkg::WORD_W-rotor_pkg::ROT_AMOUNT-1:0],
			mixed[rotor_pkg::WORD_W-1:rotor_pkg::WORD_W-rotor_pkg::ROT_AMOUNT]};
	endfunction

	function automatic rotor_pkg::word_t rand_word();
		logic [63:0] raw;
		raw = {$urandom(), $urandom()};
		return raw[rotor_pkg::WORD_W-1:0];
	endfunction

	task automatic check(input string name, input rotor_pkg::word_t actual,
		input rotor_pkg::word_t expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("mismatch at %0t: %s = %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic set_shadow(input rotor_pkg::word_t base);
		for (int a = 0; a < rotor_pkg::DEPTH; a++) begin
			shadow[a] = base + rotor_pkg::word_t'(a);
		end
	endtask

	task automatic wait_idle();
		@(negedge clock);
		while (busy) @(negedge clock);
	endtask

	task automatic sweep();
		sweep_req = 1'b1;
		wait (!sweep_req);
	endtask

	task automatic start_init(input rotor_pkg::word_t value);
		@(posedge clock);
		init_cmd <= 1'b1;
		seed <= value;
		@(posedge clock);
		init_cmd <= 1'b0;
	endtask

	task automatic start_step(input rotor_pkg::addr_t addr);
		@(posedge clock);
		step_cmd <= 1'b1;
		step_addr <= addr;
		@(posedge clock);
		step_cmd <= 1'b0;
	endtask

	task automatic run_step(input rotor_pkg::addr_t addr);
		start_step(addr);
		wait_idle();
		shadow[addr] = ref_step(shadow[addr]);
		sweep();
	endtask

	// both commands arrive while the DUT is busy, so neither may take effect.
	task automatic pulse_ignored(input rotor_pkg::addr_t addr);
		@(negedge clock);
		check("busy", rotor_pkg::word_t'(busy), rotor_pkg::word_t'(1));
		@(posedge clock);
		step_cmd <= 1'b1;
		step_addr <= addr;
		@(posedge clock);
		step_cmd <= 1'b0;
		init_cmd <= 1'b1;
		@(posedge clock);
		init_cmd <= 1'b0;
	endtask

	// the compare process reads every word back whenever a sweep is requested.
	initial begin
		forever begin
			wait (sweep_req);
			for (int a = 0; a < rotor_pkg::DEPTH; a++) begin
				@(posedge clock);
				read_addr <= rotor_pkg::addr_t'(a);
				@(negedge clock);
				check($sformatf("read_data[%0d]", a), read_data, shadow[a]);
			end
			sweep_req = 1'b0;
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count = cycle_count + 1;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		rotor_pkg::word_t first_seed;
		rotor_pkg::word_t second_seed;
		rotor_pkg::addr_t addr;
		int unsigned rng_init;
		rng_init = $urandom(RAND_SEED);
		error_count = 0;
		check_count = 0;
		sweep_req = 1'b0;
		resetn = 1'b1;
		init_cmd = 1'b0;
		step_cmd = 1'b0;
		step_addr = '0;
		seed = '0;
		read_addr = '0;
		repeat (2) @(posedge clock);
		resetn <= 1'b0;
		@(negedge clock);
		check("busy", rotor_pkg::word_t'(busy), rotor_pkg::word_t'(0));

		first_seed = rand_word();
		start_init(first_seed);
		wait_idle();
		set_shadow(first_seed);
		sweep();

		run_step(4'd9);
		repeat (REPEAT_STEPS) run_step(4'd5);
		for (int i = 0; i < RANDOM_STEPS; i++) begin
			addr = rotor_pkg::addr_t'($urandom_range(rotor_pkg::DEPTH - 1));
			run_step(addr);
		end

		start_step(4'd2);
		pulse_ignored(4'd7);
		wait_idle();
		shadow[2] = ref_step(shadow[2]);
		sweep();

		// a second init in mid-run, with a step pulse that must be dropped.
		second_seed = rand_word();
		start_init(second_seed);
		pulse_ignored(4'd11);
		wait_idle();
		set_shadow(second_seed);
		sweep();

		run_step(4'd0);
		run_step(4'd15);

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rotor.f */
rtl/rotor_pkg.sv
rtl/state_memory.sv
rtl/memory_control.sv
rtl/word_datapath.sv
rtl/step_sequencer.sv
rtl/rotor_top.sv
bench/tb_rotor.sv
